// ==== video_pkg.sv ====
/* raster and colour types for the 640x480 video pipeline
   tiles are 32x32 pixels, colour is 3-bit rgb with red in the top bit */
package video_pkg;

   typedef logic [2:0] rgb_t;

   localparam rgb_t BLACK   = 3'b000;
   localparam rgb_t RED     = 3'b100;
   localparam rgb_t MAGENTA = 3'b101;
   localparam rgb_t YELLOW  = 3'b110;
   localparam rgb_t WHITE   = 3'b111;

   localparam int TILE_BITS = 5;   // 32 pixel tiles

   typedef struct packed {
      logic [9:0] x;
      logic [8:0] y;
      logic       active;   // inside visible area
   } pixel_pos_t;

   // which object owns the current tile
   typedef enum logic [2:0] {
      NONE,
      INVADER,
      SHIP,
      BULLET,
      SMILEY,
      SAD,
      CHESS
   } sprite_kind_t;

   typedef struct packed {
      pixel_pos_t   pos;
      sprite_kind_t kind;
      logic         sprite_bit;   // bitmap bit at this pixel
   } fetch_t;

endpackage

// ==== game_pkg.sv ====
/* game state as written by the host, and the APB register map
   addresses are byte offsets on a 5-bit APB address */
package game_pkg;

   typedef enum logic [1:0] {
      PLAYING      = 2'd0,
      YOU_WIN      = 2'd1,
      GAME_OVER    = 2'd2,
      TEST_PATTERN = 2'd3
   } gameplay_t;

   typedef struct packed {
      gameplay_t   gameplay;
      logic [19:0] invaders;        // one bit per tile column
      logic [3:0]  invaders_line;   // tile row of the invaders
      logic [4:0]  ship_x;
      logic [4:0]  bullet_x;
      logic [3:0]  bullet_y;
      logic        bullet_flying;
   } game_state_t;

   localparam logic [3:0] SHIP_ROW = 4'd13;

   // register map
   localparam logic [4:0] ADDR_GAMEPLAY = 5'h00;
   localparam logic [4:0] ADDR_INVADERS = 5'h04;
   localparam logic [4:0] ADDR_LINE     = 5'h08;
   localparam logic [4:0] ADDR_SHIP     = 5'h0C;
   localparam logic [4:0] ADDR_BULLET   = 5'h10;   // x 4:0, y 8:5, flying 9

endpackage

// ==== game_regs.sv ====
/* APB3 slave, zero wait states; writes land in a pending copy of the state
   that is handed to the display only on the frame start pulse */
module game_regs (
   input  logic                  i_clk,
   input  logic                  i_reset,
   input  logic                  i_psel,
   input  logic                  i_penable,
   input  logic                  i_pwrite,
   input  logic [4:0]            i_paddr,
   input  logic [31:0]           i_pwdata,
   output logic [31:0]           o_prdata,
   output logic                  o_pready,
   output logic                  o_pslverr,
   input  logic                  i_frame_start,
   output game_pkg::game_state_t o_state
);

   game_pkg::game_state_t pending;
   logic                  addr_ok;
   logic                  wr_en;

   // read mux and address decode
   always_comb begin
      addr_ok  = 1'b1;
      o_prdata = 32'b0;
      case (i_paddr)
         game_pkg::ADDR_GAMEPLAY: o_prdata = {30'b0, pending.gameplay};
         game_pkg::ADDR_INVADERS: o_prdata = {12'b0, pending.invaders};
         game_pkg::ADDR_LINE:     o_prdata = {28'b0, pending.invaders_line};
         game_pkg::ADDR_SHIP:     o_prdata = {27'b0, pending.ship_x};
         game_pkg::ADDR_BULLET:
            o_prdata = {22'b0, pending.bullet_flying, pending.bullet_y, pending.bullet_x};
         default:                 addr_ok = 1'b0;
      endcase
   end

   assign o_pready  = 1'b1;
   assign o_pslverr = i_psel && i_penable && !addr_ok;
   assign wr_en     = i_psel && i_penable && i_pwrite && addr_ok;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         pending <= '0;
         o_state <= '0;
      end else begin
         if (wr_en) begin
            case (i_paddr)
               game_pkg::ADDR_GAMEPLAY:
                  pending.gameplay <= game_pkg::gameplay_t'(i_pwdata[1:0]);
               game_pkg::ADDR_INVADERS: pending.invaders      <= i_pwdata[19:0];
               game_pkg::ADDR_LINE:     pending.invaders_line <= i_pwdata[3:0];
               game_pkg::ADDR_SHIP:     pending.ship_x        <= i_pwdata[4:0];
               game_pkg::ADDR_BULLET: begin
                  pending.bullet_x      <= i_pwdata[4:0];
                  pending.bullet_y      <= i_pwdata[8:5];
                  pending.bullet_flying <= i_pwdata[9];
               end
               default: ;
            endcase
         end
         if (i_frame_start)
            o_state <= pending;   // old value wins on a same-cycle write
      end
   end

endmodule

// ==== raster_timing.sv ====
/* free running raster counters, one pixel per clock, syncs active low
   line and frame totals must stay below 1024 */
module raster_timing #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic                  i_clk,
   input  logic                  i_reset,
   output video_pkg::pixel_pos_t o_pos,
   output logic                  o_hsync,
   output logic                  o_vsync,
   output logic                  o_frame_start
);

   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int HS_START = H_ACTIVE + H_FRONT;
   localparam int VS_START = V_ACTIVE + V_FRONT;

   logic [9:0] h_cnt;
   logic [9:0] v_cnt;
   logic       h_last;
   logic       v_last;

   assign h_last = (h_cnt == 10'(H_TOTAL - 1));
   assign v_last = (v_cnt == 10'(V_TOTAL - 1));

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_last) begin
         h_cnt <= '0;
         v_cnt <= v_last ? 10'd0 : v_cnt + 10'd1;
      end else begin
         h_cnt <= h_cnt + 10'd1;
      end
   end

   assign o_pos.x      = h_cnt;
   assign o_pos.y      = v_cnt[8:0];   // only meaningful in the active rows
   assign o_pos.active = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));

   assign o_hsync = !((h_cnt >= 10'(HS_START)) && (h_cnt < 10'(HS_START + H_SYNC)));
   assign o_vsync = !((v_cnt >= 10'(VS_START)) && (v_cnt < 10'(VS_START + V_SYNC)));

   // last position of the frame, state swaps on the next edge
   assign o_frame_start = h_last && v_last;

endmodule

// ==== sprite_fetch.sv ====
/* pipeline stage one, picks the sprite owning a tile and reads its bitmap bit
   bitmap bit 0 is the leftmost pixel of a tile row */
module sprite_fetch (
   input  logic                  i_clk,
   input  logic                  i_reset,
   input  video_pkg::pixel_pos_t i_pos,
   input  logic                  i_hsync,
   input  logic                  i_vsync,
   input  game_pkg::game_state_t i_state,
   output video_pkg::fetch_t     o_fetch,
   output logic                  o_hsync,
   output logic                  o_vsync
);

   // invader and ship are drawn with doubled rows, indexed by y/2
   localparam logic [31:0] INVADER_ROWS [16] = '{
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00600600, 32'h00181800, 32'h007FFE00, 32'h01E7E780,
      32'h07FFFFE0, 32'h067FFE60, 32'h06600660, 32'h001E7800,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000
   };
   localparam logic [31:0] SHIP_ROWS [16] = '{
      32'h00018000, 32'h00018000, 32'h0007E000, 32'h0007E000,
      32'h0187E180, 32'h0187E180, 32'h019FF980, 32'h01FE7F80,
      32'h61F81F86, 32'h61F81F86, 32'h61FFFF86, 32'h67FFFFE6,
      32'h7FFFFFFE, 32'h7E7FFE7E, 32'h78799E1E, 32'h60018006
   };
   localparam logic [31:0] BULLET_ROWS [16] = '{   // upper half of tile only
      32'h0003C000, 32'h0005E000, 32'h000AF000, 32'h0018F800,
      32'h003FFC00, 32'h003F3C00, 32'h007F1E00, 32'h007E1E00,
      32'h007F1E00, 32'h007E1E00, 32'h007E3E00, 32'h007F3E00,
      32'h007FFE00, 32'h00000000, 32'h005FFE00, 32'h005FFE00
   };
   localparam logic [31:0] SMILEY_ROWS [32] = '{
      32'hFFFFFFFF, 32'hFFFFFFFF, 32'hF800001F, 32'hE0000007,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h81E00781, 32'h81E00781, 32'h81E00781, 32'h81E00781,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h86000061,
      32'h830000C1, 32'h81800181, 32'h80C00301, 32'h80600601,
      32'h801FFC01, 32'h80000001, 32'h80000001, 32'h80000001,
      32'hE0000007, 32'hF800001F, 32'hFFFFFFFF, 32'hFFFFFFFF
   };
   localparam logic [31:0] SAD_ROWS [32] = '{
      32'hFFFFFFFF, 32'hFFFFFFFF, 32'hF800001F, 32'hE0000007,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h81E00781, 32'h81E00781, 32'h81E00781, 32'h81E00781,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h801FFC01, 32'h80300601, 32'h80600301, 32'h80C00181,
      32'h818000C1, 32'h83000061, 32'h80000001, 32'h80000001,
      32'hE0000007, 32'hF800001F, 32'hFFFFFFFF, 32'hFFFFFFFF
   };

   logic [4:0]              tile_col;
   logic [3:0]              tile_row;
   logic [4:0]              off_x;
   logic [4:0]              off_y;
   logic [31:0]             inv_row;   // zero padded so blanking columns read 0
   video_pkg::sprite_kind_t kind_sel;
   logic                    bit_sel;

   assign tile_col = i_pos.x[9:video_pkg::TILE_BITS];
   assign tile_row = i_pos.y[8:video_pkg::TILE_BITS];
   assign off_x    = i_pos.x[video_pkg::TILE_BITS-1:0];
   assign off_y    = i_pos.y[video_pkg::TILE_BITS-1:0];
   assign inv_row  = {12'b0, i_state.invaders};

   always_comb begin
      kind_sel = video_pkg::NONE;
      bit_sel  = 1'b0;
      case (i_state.gameplay)
         game_pkg::YOU_WIN: begin
            kind_sel = video_pkg::SMILEY;
            bit_sel  = SMILEY_ROWS[off_y][off_x];
         end
         game_pkg::GAME_OVER: begin
            kind_sel = video_pkg::SAD;
            bit_sel  = SAD_ROWS[off_y][off_x];
         end
         game_pkg::TEST_PATTERN: begin
            kind_sel = video_pkg::CHESS;
            bit_sel  = tile_col[0] ^ tile_row[0];
         end
         default: begin   // playing, bullet over ship over invader
            if (i_state.bullet_flying && tile_col == i_state.bullet_x &&
                tile_row == i_state.bullet_y) begin
               kind_sel = video_pkg::BULLET;
               bit_sel  = !off_y[4] && BULLET_ROWS[off_y[3:0]][off_x];
            end else if (tile_col == i_state.ship_x && tile_row == game_pkg::SHIP_ROW) begin
               kind_sel = video_pkg::SHIP;
               bit_sel  = SHIP_ROWS[off_y[4:1]][off_x];
            end else if (tile_row == i_state.invaders_line && inv_row[tile_col]) begin
               kind_sel = video_pkg::INVADER;
               bit_sel  = INVADER_ROWS[off_y[4:1]][off_x];
            end
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      o_fetch.pos        <= i_pos;
      o_fetch.kind       <= kind_sel;
      o_fetch.sprite_bit <= bit_sel;
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_hsync <= 1'b1;
         o_vsync <= 1'b1;
      end else begin
         o_hsync <= i_hsync;
         o_vsync <= i_vsync;
      end
   end

endmodule

// ==== pixel_shade.sv ====
/* pipeline stage two, colour lookup and blanking */
module pixel_shade (
   input  logic              i_clk,
   input  logic              i_reset,
   input  video_pkg::fetch_t i_fetch,
   input  logic              i_hsync,
   input  logic              i_vsync,
   output video_pkg::rgb_t   o_rgb,
   output logic              o_hsync,
   output logic              o_vsync
);

   video_pkg::rgb_t shade;

   always_comb begin
      shade = video_pkg::BLACK;   // background and blanking
      if (i_fetch.pos.active) begin
         case (i_fetch.kind)
            video_pkg::INVADER:
               if (i_fetch.sprite_bit) shade = video_pkg::MAGENTA;
            video_pkg::SHIP:
               if (i_fetch.sprite_bit) shade = video_pkg::RED;
            video_pkg::BULLET:
               if (i_fetch.sprite_bit) shade = video_pkg::YELLOW;
            // end screens draw the face outline in black
            video_pkg::SMILEY:
               shade = i_fetch.sprite_bit ? video_pkg::BLACK : video_pkg::YELLOW;
            video_pkg::SAD:
               shade = i_fetch.sprite_bit ? video_pkg::BLACK : video_pkg::RED;
            video_pkg::CHESS:
               if (i_fetch.sprite_bit) shade = video_pkg::WHITE;
            default: shade = video_pkg::BLACK;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_rgb   <= video_pkg::BLACK;
         o_hsync <= 1'b1;
         o_vsync <= 1'b1;
      end else begin
         o_rgb   <= shade;
         o_hsync <= i_hsync;   // two stages behind the raster, like rgb
         o_vsync <= i_vsync;
      end
   end

endmodule

// ==== invaders_display.sv ====
/* game display top, i_clk must be the pixel clock (25 MHz for 640x480)
   rgb and syncs lag the raster by 2 clocks; APB writes show from the next frame */
module invaders_display #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic            i_clk,
   input  logic            i_reset,
   input  logic            i_psel,
   input  logic            i_penable,
   input  logic            i_pwrite,
   input  logic [4:0]      i_paddr,
   input  logic [31:0]     i_pwdata,
   output logic [31:0]     o_prdata,
   output logic            o_pready,
   output logic            o_pslverr,
   output video_pkg::rgb_t o_rgb,
   output logic            o_hsync,
   output logic            o_vsync
);

   game_pkg::game_state_t live_state;
   video_pkg::pixel_pos_t pos;
   video_pkg::fetch_t     fetch;
   logic                  frame_start;
   logic                  raw_hsync;
   logic                  raw_vsync;
   logic                  fetch_hsync;
   logic                  fetch_vsync;

   game_regs u_regs (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .o_pready     (o_pready),
      .o_pslverr    (o_pslverr),
      .i_frame_start(frame_start),
      .o_state      (live_state)
   );

   raster_timing #(
      .H_ACTIVE(H_ACTIVE),
      .H_FRONT (H_FRONT),
      .H_SYNC  (H_SYNC),
      .H_BACK  (H_BACK),
      .V_ACTIVE(V_ACTIVE),
      .V_FRONT (V_FRONT),
      .V_SYNC  (V_SYNC),
      .V_BACK  (V_BACK)
   ) u_timing (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .o_pos        (pos),
      .o_hsync      (raw_hsync),
      .o_vsync      (raw_vsync),
      .o_frame_start(frame_start)
   );

   sprite_fetch u_fetch (
      .i_clk  (i_clk),
      .i_reset(i_reset),
      .i_pos  (pos),
      .i_hsync(raw_hsync),
      .i_vsync(raw_vsync),
      .i_state(live_state),
      .o_fetch(fetch),
      .o_hsync(fetch_hsync),
      .o_vsync(fetch_vsync)
   );

   pixel_shade u_shade (
      .i_clk  (i_clk),
      .i_reset(i_reset),
      .i_fetch(fetch),
      .i_hsync(fetch_hsync),
      .i_vsync(fetch_vsync),
      .o_rgb  (o_rgb),
      .o_hsync(o_hsync),
      .o_vsync(o_vsync)
   );

endmodule

// ==== tb_invaders_display.sv ====
/* directed testbench, short blanking gives 672x486 clock frames
   the output pixel position is rebuilt from the falling edge of o_vsync */
module tb_invaders_display;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int H_ACTIVE = 640;
   localparam int H_FRONT  = 8;
   localparam int H_SYNC   = 16;
   localparam int H_BACK   = 8;
   localparam int V_ACTIVE = 480;
   localparam int V_FRONT  = 2;
   localparam int V_SYNC   = 2;
   localparam int V_BACK   = 2;
   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int HS_START = H_ACTIVE + H_FRONT;
   localparam int VS_START = V_ACTIVE + V_FRONT;
   localparam int TILE     = 1 << video_pkg::TILE_BITS;
   localparam int CLK_NS   = 8;
   localparam int FRAMES_USED = 15;   // about 2 frames per screen test
   localparam int WATCHDOG_NS = (FRAMES_USED + 9) * H_TOTAL * V_TOTAL * CLK_NS;

   // reference shapes, bit 0 is the leftmost pixel
   localparam logic [31:0] INVADER_BMP [16] = '{
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00600600, 32'h00181800,
      32'h007FFE00, 32'h01E7E780, 32'h07FFFFE0, 32'h067FFE60, 32'h06600660, 32'h001E7800,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000
   };
   localparam logic [31:0] SHIP_BMP [16] = '{
      32'h00018000, 32'h00018000, 32'h0007E000, 32'h0007E000, 32'h0187E180, 32'h0187E180,
      32'h019FF980, 32'h01FE7F80, 32'h61F81F86, 32'h61F81F86, 32'h61FFFF86, 32'h67FFFFE6,
      32'h7FFFFFFE, 32'h7E7FFE7E, 32'h78799E1E, 32'h60018006
   };
   localparam logic [31:0] BULLET_BMP [16] = '{
      32'h0003C000, 32'h0005E000, 32'h000AF000, 32'h0018F800, 32'h003FFC00, 32'h003F3C00,
      32'h007F1E00, 32'h007E1E00, 32'h007F1E00, 32'h007E1E00, 32'h007E3E00, 32'h007F3E00,
      32'h007FFE00, 32'h00000000, 32'h005FFE00, 32'h005FFE00
   };
   localparam logic [31:0] SMILEY_BMP [32] = '{
      32'hFFFFFFFF, 32'hFFFFFFFF, 32'hF800001F, 32'hE0000007, 32'h80000001, 32'h80000001,
      32'h80000001, 32'h80000001, 32'h81E00781, 32'h81E00781, 32'h81E00781, 32'h81E00781,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h80000001, 32'h86000061, 32'h830000C1, 32'h81800181, 32'h80C00301, 32'h80600601,
      32'h801FFC01, 32'h80000001, 32'h80000001, 32'h80000001, 32'hE0000007, 32'hF800001F,
      32'hFFFFFFFF, 32'hFFFFFFFF
   };
   localparam logic [31:0] SAD_BMP [32] = '{
      32'hFFFFFFFF, 32'hFFFFFFFF, 32'hF800001F, 32'hE0000007, 32'h80000001, 32'h80000001,
      32'h80000001, 32'h80000001, 32'h81E00781, 32'h81E00781, 32'h81E00781, 32'h81E00781,
      32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001, 32'h80000001,
      32'h80000001, 32'h80000001, 32'h801FFC01, 32'h80300601, 32'h80600301, 32'h80C00181,
      32'h818000C1, 32'h83000061, 32'h80000001, 32'h80000001, 32'hE0000007, 32'hF800001F,
      32'hFFFFFFFF, 32'hFFFFFFFF
   };

   logic                  i_clk;
   logic                  i_reset;
   logic                  i_psel;
   logic                  i_penable;
   logic                  i_pwrite;
   logic [4:0]            i_paddr;
   logic [31:0]           i_pwdata;
   logic [31:0]           o_prdata;
   logic                  o_pready;
   logic                  o_pslverr;
   video_pkg::rgb_t       o_rgb;
   logic                  o_hsync;
   logic                  o_vsync;

   logic [31:0]           lcg_state = 32'hd343_7e93;
   int                    trk_x;
   int                    trk_y;
   logic                  trk_valid;
   logic                  vsync_d;
   game_pkg::game_state_t cur_state;   // state on screen right now

   invaders_display #(
      .H_ACTIVE(H_ACTIVE),
      .H_FRONT (H_FRONT),
      .H_SYNC  (H_SYNC),
      .H_BACK  (H_BACK),
      .V_ACTIVE(V_ACTIVE),
      .V_FRONT (V_FRONT),
      .V_SYNC  (V_SYNC),
      .V_BACK  (V_BACK)
   ) uut (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_psel   (i_psel),
      .i_penable(i_penable),
      .i_pwrite (i_pwrite),
      .i_paddr  (i_paddr),
      .i_pwdata (i_pwdata),
      .o_prdata (o_prdata),
      .o_pready (o_pready),
      .o_pslverr(o_pslverr),
      .o_rgb    (o_rgb),
      .o_hsync  (o_hsync),
      .o_vsync  (o_vsync)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_NS / 2) i_clk = ~i_clk;
   end

   // position of the pixel shown on the outputs after this edge
   always @(posedge i_clk) begin
      if (i_reset) begin
         trk_valid <= 1'b0;
         vsync_d   <= 1'b1;
      end else begin
         vsync_d <= o_vsync;
         if (vsync_d && !o_vsync) begin   // last pixel was (0, VS_START)
            trk_valid <= 1'b1;
            trk_x     <= 1;
            trk_y     <= VS_START;
         end else if (trk_x == H_TOTAL - 1) begin
            trk_x <= 0;
            trk_y <= (trk_y == V_TOTAL - 1) ? 0 : trk_y + 1;
         end else begin
            trk_x <= trk_x + 1;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      report_failure("watchdog expired, the display never reached the awaited pixel");
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_rgb(input string name, input video_pkg::rgb_t got,
                            input video_pkg::rgb_t exp);
      if (got !== exp)
         report_failure($sformatf("FAILED at %0t: %s = %b, expected %b, pixel (%0d,%0d)",
                                  $time, name, got, exp, trk_x, trk_y));
   endtask

   task automatic check_sync(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("FAILED at %0t: %s = %b, expected %b, pixel (%0d,%0d)",
                                  $time, name, got, exp, trk_x, trk_y));
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
         report_failure($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // colour from the mode, priority and bitmap rules
   function automatic video_pkg::rgb_t expected_rgb(input int x, input int y,
                                                    input game_pkg::game_state_t st);
      int col;
      int row;
      int ox;
      int oy;
      if (x >= H_ACTIVE || y >= V_ACTIVE)
         return video_pkg::BLACK;
      col = x / TILE;
      row = y / TILE;
      ox  = x % TILE;
      oy  = y % TILE;
      case (st.gameplay)
         game_pkg::YOU_WIN:
            return SMILEY_BMP[oy][ox] ? video_pkg::BLACK : video_pkg::YELLOW;
         game_pkg::GAME_OVER:
            return SAD_BMP[oy][ox] ? video_pkg::BLACK : video_pkg::RED;
         game_pkg::TEST_PATTERN:
            return ((col % 2) != (row % 2)) ? video_pkg::WHITE : video_pkg::BLACK;
         default: ;
      endcase
      if (st.bullet_flying && col == st.bullet_x && row == st.bullet_y)
         return (oy < 16 && BULLET_BMP[oy][ox]) ? video_pkg::YELLOW : video_pkg::BLACK;
      if (col == st.ship_x && row == game_pkg::SHIP_ROW)
         return SHIP_BMP[oy / 2][ox] ? video_pkg::RED : video_pkg::BLACK;
      if (row == st.invaders_line && st.invaders[col])
         return INVADER_BMP[oy / 2][ox] ? video_pkg::MAGENTA : video_pkg::BLACK;
      return video_pkg::BLACK;
   endfunction

   function automatic game_pkg::game_state_t random_playing_state();
      game_pkg::game_state_t st;
      logic [31:0]           r;
      st               = '0;
      st.gameplay      = game_pkg::PLAYING;
      st.invaders      = 20'(next_random());
      st.invaders_line = 4'(next_random() % 15);
      st.ship_x        = 5'(next_random() % 20);
      st.bullet_x      = 5'(next_random() % 20);
      r                = next_random();
      st.bullet_y      = 4'(r % 15);
      st.bullet_flying = r[31];
      return st;
   endfunction

   task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b1;
      i_paddr   = addr;
      i_pwdata  = data;
      @(negedge i_clk);
      i_penable = 1'b1;
      @(posedge i_clk);
      check_flag("o_pready", o_pready, 1'b1);
      err = o_pslverr;
      @(negedge i_clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = addr;
      @(negedge i_clk);
      i_penable = 1'b1;
      @(posedge i_clk);
      check_flag("o_pready", o_pready, 1'b1);
      data = o_prdata;
      err  = o_pslverr;
      @(negedge i_clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic write_state(input game_pkg::game_state_t st);
      logic err;
      apb_write(game_pkg::ADDR_GAMEPLAY, {30'b0, st.gameplay}, err);
      apb_write(game_pkg::ADDR_INVADERS, {12'b0, st.invaders}, err);
      apb_write(game_pkg::ADDR_LINE, {28'b0, st.invaders_line}, err);
      apb_write(game_pkg::ADDR_SHIP, {27'b0, st.ship_x}, err);
      apb_write(game_pkg::ADDR_BULLET, {22'b0, st.bullet_flying, st.bullet_y, st.bullet_x}, err);
   endtask

   // returns at once if the outputs already show that pixel
   task automatic wait_for_pixel(input int x, input int y);
      while (!(trk_valid && trk_x == x && trk_y == y))
         @(negedge i_clk);
   endtask

   // every output pixel from row y0 to the end of the frame
   task automatic check_rows(input int y0, input game_pkg::game_state_t st);
      wait_for_pixel(0, y0);
      do begin
         check_rgb("o_rgb", o_rgb, expected_rgb(trk_x, trk_y, st));
         check_sync("o_hsync", o_hsync, !(trk_x >= HS_START && trk_x < HS_START + H_SYNC));
         check_sync("o_vsync", o_vsync, !(trk_y >= VS_START && trk_y < VS_START + V_SYNC));
         @(negedge i_clk);
      end while (!(trk_x == 0 && trk_y == 0));
   endtask

   // write mid frame, then check the whole next frame
   task automatic run_screen(input game_pkg::game_state_t st);
      wait_for_pixel(0, 200);
      write_state(st);
      check_rows(0, st);
      cur_state = st;
   endtask

   task automatic register_access();
      logic [4:0]  addr [5];
      logic [31:0] mask [5];
      logic [31:0] wdata [5];
      logic [31:0] rdata;
      logic        err;
      addr = '{game_pkg::ADDR_GAMEPLAY, game_pkg::ADDR_INVADERS, game_pkg::ADDR_LINE,
               game_pkg::ADDR_SHIP, game_pkg::ADDR_BULLET};
      mask = '{32'h3, 32'hF_FFFF, 32'hF, 32'h1F, 32'h3FF};
      for (int i = 0; i < 5; i++) begin
         wdata[i] = next_random();
         apb_write(addr[i], wdata[i], err);
         check_flag("o_pslverr", err, 1'b0);
         apb_read(addr[i], rdata, err);
         check_word("o_prdata", rdata, wdata[i] & mask[i]);
         check_flag("o_pslverr", err, 1'b0);
      end
      apb_write(5'h14, 32'hFFFF_FFFF, err);
      check_flag("o_pslverr", err, 1'b1);
      apb_write(5'h06, 32'hFFFF_FFFF, err);   // misaligned
      check_flag("o_pslverr", err, 1'b1);
      apb_read(5'h1C, rdata, err);
      check_word("o_prdata", rdata, 32'b0);
      check_flag("o_pslverr", err, 1'b1);
      for (int i = 0; i < 5; i++) begin
         apb_read(addr[i], rdata, err);
         check_word("o_prdata", rdata, wdata[i] & mask[i]);
      end
   endtask

   task automatic playing_screens();
      game_pkg::game_state_t st;
      st = random_playing_state();
      run_screen(st);
      st               = random_playing_state();
      st.bullet_flying = 1'b1;
      st.bullet_x      = st.ship_x;
      st.bullet_y      = game_pkg::SHIP_ROW;
      run_screen(st);
      st                     = random_playing_state();
      st.bullet_flying       = 1'b1;
      st.bullet_y            = st.invaders_line;
      st.invaders[st.bullet_x] = 1'b1;   // bullet over an invader
      run_screen(st);
   endtask

   task automatic end_screens();
      game_pkg::game_state_t st;
      st          = random_playing_state();
      st.gameplay = game_pkg::YOU_WIN;
      run_screen(st);
      st.gameplay = game_pkg::GAME_OVER;
      run_screen(st);
   endtask

   task automatic chessboard_screen();
      game_pkg::game_state_t st;
      st          = random_playing_state();
      st.gameplay = game_pkg::TEST_PATTERN;
      run_screen(st);
   endtask

   task automatic frame_boundary_update();
      game_pkg::game_state_t st;
      st = random_playing_state();
      wait_for_pixel(0, 200);
      write_state(st);
      check_rows(240, cur_state);   // rest of this frame keeps the old state
      check_rows(0, st);
      cur_state = st;
   endtask

   initial begin
      i_reset   = 1'b1;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      cur_state = '0;
      repeat (16) @(negedge i_clk);
      i_reset = 1'b0;
      check_rgb("o_rgb", o_rgb, video_pkg::BLACK);
      check_sync("o_hsync", o_hsync, 1'b1);
      check_sync("o_vsync", o_vsync, 1'b1);
      check_flag("o_pslverr", o_pslverr, 1'b0);
      register_access();
      playing_screens();
      end_screens();
      chessboard_screen();
      frame_boundary_update();
      $display("Verification passed");
      $finish;
   end

endmodule

// ==== vlog.f ====
video_pkg.sv
game_pkg.sv
game_regs.sv
raster_timing.sv
sprite_fetch.sv
pixel_shade.sv
invaders_display.sv
tb_invaders_display.sv

// ==== Bender.yml ====
package:
  name: invaders_display

sources:
  - video_pkg.sv
  - game_pkg.sv
  - game_regs.sv
  - raster_timing.sv
  - sprite_fetch.sv
  - pixel_shade.sv
  - invaders_display.sv
  - target: test
    files:
      - tb_invaders_display.sv
